// ==== common/bt_pkg.sv ====
/*
	Shared widths, serial timing and frame lengths for the Bluetooth bridge.
	RESP_BYTES must be even because reply bytes are paired into words.
	FIFO_WORDS must be a power of two so the FIFO pointers wrap on their own.
*/

`default_nettype none

package bt_pkg;

	// Data widths
	localparam int WORD_W = 16;
	localparam int BYTE_W = 8;

	// Serial timing, one start bit, eight data bits and one stop bit
	localparam int CLKS_PER_BIT = 16;
	localparam int FRAME_BITS = BYTE_W + 2;
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int BIT_IDX_W = $clog2(FRAME_BITS);

	// Frame lengths
	localparam int SENSOR_WORDS = 4;
	localparam int RESP_BYTES = 4;
	localparam int SAMPLE_CNT_W = $clog2(SENSOR_WORDS + 1);
	localparam int REPLY_CNT_W = $clog2(RESP_BYTES + 1);

	// FIFO depth in 16-bit words
	localparam int FIFO_WORDS = 16;
	localparam int FIFO_AW = $clog2(FIFO_WORDS);

	typedef enum logic [3:0] {
		IDLE,
		WAIT_DATA,
		LOAD_WORD,
		STORED,
		POP_BYTE,
		WAIT_LINK,
		SEND_BYTE,
		NEXT_BYTE,
		GET_REPLY,
		WAIT_DEMAND,
		READ_WORD,
		OFFER_WORD,
		DONE
	} link_state_e;

endpackage

`default_nettype wire

// ==== src/tx_fifo.sv ====
/*
	Word-in, byte-out FIFO. Each word leaves as its high byte, then its low byte.
	A push into a full FIFO is dropped. The popped byte appears one cycle later.
*/

`timescale 1ns/1ps
`default_nettype none

module tx_fifo (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      push_i,
	input  logic [bt_pkg::WORD_W-1:0] wdata_i,
	input  logic                      pop_i,
	output logic [bt_pkg::BYTE_W-1:0] rbyte_o,
	output logic                      empty_o,
	output logic                      full_o
);
	import bt_pkg::*;

	logic [WORD_W-1:0]  mem_q [FIFO_WORDS];
	logic [FIFO_AW-1:0] wr_ptr_q;
	logic [FIFO_AW-1:0] rd_ptr_q;
	logic [FIFO_AW:0]   count_q;
	logic               lo_sel_q;
	logic [BYTE_W-1:0]  rbyte_q;
	logic               do_push;
	logic               do_pop;
	logic               word_done;

	assign empty_o = (count_q == '0);
	assign full_o = (count_q == (FIFO_AW + 1)'(FIFO_WORDS));
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;
	// A word leaves the memory once its low byte is popped
	assign word_done = do_pop && lo_sel_q;
	assign rbyte_o = rbyte_q;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			lo_sel_q <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)
				lo_sel_q <= !lo_sel_q;
			if (word_done)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (do_push && !word_done)
				count_q <= count_q + 1'b1;
			else if (!do_push && word_done)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (do_push)
			mem_q[wr_ptr_q] <= wdata_i;
		if (do_pop)
			rbyte_q <= lo_sel_q ? mem_q[rd_ptr_q][BYTE_W-1:0] : mem_q[rd_ptr_q][WORD_W-1:BYTE_W];
	end

endmodule

`default_nettype wire

// ==== src/rx_fifo.sv ====
/*
	Byte-in, word-out FIFO. The first byte of a pair becomes the high byte.
	Empty means no complete word is stored; a lone high byte does not count.
	A byte arriving while the FIFO is full is dropped.
*/

`timescale 1ns/1ps
`default_nettype none

module rx_fifo (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      push_i,
	input  logic [bt_pkg::BYTE_W-1:0] wbyte_i,
	input  logic                      pop_i,
	output logic [bt_pkg::WORD_W-1:0] rword_o,
	output logic                      empty_o,
	output logic                      full_o
);
	import bt_pkg::*;

	logic [WORD_W-1:0]  mem_q [FIFO_WORDS];
	logic [FIFO_AW-1:0] wr_ptr_q;
	logic [FIFO_AW-1:0] rd_ptr_q;
	logic [FIFO_AW:0]   count_q;
	logic               hi_valid_q;
	logic [BYTE_W-1:0]  hold_q;
	logic [WORD_W-1:0]  rword_q;
	logic               byte_in;
	logic               do_write;
	logic               do_pop;

	assign empty_o = (count_q == '0);
	assign full_o = (count_q == (FIFO_AW + 1)'(FIFO_WORDS));
	assign byte_in = push_i && !full_o;
	assign do_write = byte_in && hi_valid_q;
	assign do_pop = pop_i && !empty_o;
	assign rword_o = rword_q;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			hi_valid_q <= 1'b0;
		end
		else
		begin
			if (byte_in)
				hi_valid_q <= !hi_valid_q;
			if (do_write)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (do_write && !do_pop)
				count_q <= count_q + 1'b1;
			else if (!do_write && do_pop)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		// High byte waits here for its partner
		if (byte_in && !hi_valid_q)
			hold_q <= wbyte_i;
		if (do_write)
			mem_q[wr_ptr_q] <= {hold_q, wbyte_i};
		if (do_pop)
			rword_q <= mem_q[rd_ptr_q];
	end

endmodule

`default_nettype wire

// ==== uart/uart_tx.sv ====
/*
	8N1 transmitter. byte_i is taken on the cycle start_i is high while idle;
	a start pulse during a frame is ignored. done_o is high in the last
	cycle of the stop bit, so a frame spans 10 bit periods after the start.
*/

`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      start_i,
	input  logic [bt_pkg::BYTE_W-1:0] byte_i,
	output logic                      txd_o,
	output logic                      done_o
);
	import bt_pkg::*;

	localparam logic [BIT_CNT_W-1:0] CNT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [BIT_IDX_W-1:0] BIT_LAST = BIT_IDX_W'(FRAME_BITS - 1);

	logic                  busy_q;
	logic [BIT_CNT_W-1:0]  cnt_q;
	logic [BIT_IDX_W-1:0]  bit_q;
	logic [FRAME_BITS-1:0] shift_q;
	logic                  bit_end;

	assign bit_end = busy_q && (cnt_q == CNT_LAST);
	// Line idles high
	assign txd_o = busy_q ? shift_q[0] : 1'b1;
	assign done_o = bit_end && (bit_q == BIT_LAST);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy_q <= 1'b0;
			cnt_q <= '0;
			bit_q <= '0;
		end
		else if (!busy_q)
		begin
			if (start_i)
			begin
				busy_q <= 1'b1;
				cnt_q <= '0;
				bit_q <= '0;
			end
		end
		else if (bit_end)
		begin
			cnt_q <= '0;
			if (bit_q == BIT_LAST)
				busy_q <= 1'b0;
			else
				bit_q <= bit_q + 1'b1;
		end
		else
			cnt_q <= cnt_q + 1'b1;
	end

	// Stop, data LSB first, start; shifted out from bit 0
	always_ff @(posedge clock)
	begin
		if (!busy_q && start_i)
			shift_q <= {1'b1, byte_i, 1'b0};
		else if (bit_end)
			shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
	end

endmodule

`default_nettype wire

// ==== uart/uart_rx.sv ====
/*
	8N1 receiver. The line is synchronized with two flops, so bytes show up
	a few cycles after their stop bit. Bits are sampled near their middle.
	A start bit that is gone at mid-bit, or a low stop bit, drops the byte.
*/

`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      rxd_i,
	output logic [bt_pkg::BYTE_W-1:0] byte_o,
	output logic                      valid_o
);
	import bt_pkg::*;

	localparam logic [BIT_CNT_W-1:0] CNT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [BIT_CNT_W-1:0] CNT_HALF = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [BIT_IDX_W-1:0] BIT_LAST = BIT_IDX_W'(FRAME_BITS - 1);

	logic [1:0]           sync_q;
	logic                 rxd_prev_q;
	logic                 rxd_s;
	logic                 start_edge;
	logic                 busy_q;
	logic [BIT_CNT_W-1:0] cnt_q;
	logic [BIT_IDX_W-1:0] bit_q;
	logic                 sample;
	logic                 valid_q;
	logic [BYTE_W-1:0]    shift_q;

	assign rxd_s = sync_q[1];
	assign start_edge = !busy_q && rxd_prev_q && !rxd_s;
	assign sample = busy_q && (cnt_q == '0);
	assign byte_o = shift_q;
	assign valid_o = valid_q;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			sync_q <= 2'b11;
			rxd_prev_q <= 1'b1;
			busy_q <= 1'b0;
			cnt_q <= '0;
			bit_q <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			sync_q <= {sync_q[0], rxd_i};
			rxd_prev_q <= rxd_s;
			valid_q <= 1'b0;
			if (start_edge)
			begin
				// First sample lands half a bit into the start bit
				busy_q <= 1'b1;
				cnt_q <= CNT_HALF;
				bit_q <= '0;
			end
			else if (busy_q && !sample)
				cnt_q <= cnt_q - 1'b1;
			else if (sample)
			begin
				cnt_q <= CNT_LAST;
				if (bit_q == '0 && rxd_s)
					busy_q <= 1'b0;
				else if (bit_q == BIT_LAST)
				begin
					busy_q <= 1'b0;
					valid_q <= rxd_s;
				end
				else
					bit_q <= bit_q + 1'b1;
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clock)
	begin
		if (sample && bit_q != '0 && bit_q != BIT_LAST)
			shift_q <= {rxd_s, shift_q[BYTE_W-1:1]};
	end

endmodule

`default_nettype wire

// ==== src/bt_link_ctrl.sv ====
/*
	Bridge sequencer. want_at_i high selects command mode, low sensor mode,
	and must stay steady for a whole session. Sensor mode waits for a link
	before every byte; command mode sends at once and then captures
	RESP_BYTES reply bytes for the host. Nothing stalls the serial side.
*/

`timescale 1ns/1ps
`default_nettype none

module bt_link_ctrl (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      begin_i,
	input  logic                      want_at_i,
	input  logic                      data_loaded_i,
	input  logic                      knows_stored_i,
	input  logic                      data_done_i,
	input  logic                      access_rx_i,
	input  logic                      received_i,
	input  logic                      finished_rx_i,
	input  logic                      bt_state_i,
	input  logic                      tx_empty_i,
	input  logic [bt_pkg::BYTE_W-1:0] tx_rbyte_i,
	input  logic                      tx_done_i,
	input  logic                      rx_valid_i,
	output logic                      tx_push_o,
	output logic                      tx_pop_o,
	output logic                      tx_start_o,
	output logic [bt_pkg::BYTE_W-1:0] tx_byte_o,
	output logic                      rx_pop_o,
	output logic                      word_stored_o,
	output logic                      word_valid_o,
	output logic                      done_o
);
	import bt_pkg::*;

	link_state_e             state_q;
	link_state_e             state_d;
	link_state_e             byte_entry;
	logic [SAMPLE_CNT_W-1:0] word_cnt_q;
	logic [REPLY_CNT_W-1:0]  reply_cnt_q;
	logic                    pop_q;
	logic                    data_ready;
	logic                    data_complete;
	logic                    reply_last;

	// Sensor samples are always ready; the frame ends on the sample count
	assign data_ready = want_at_i ? data_loaded_i : 1'b1;
	assign data_complete = want_at_i ? data_done_i
		: (word_cnt_q == SAMPLE_CNT_W'(SENSOR_WORDS));
	// Only sensor mode checks the link, once before each byte
	assign byte_entry = want_at_i ? POP_BYTE : WAIT_LINK;
	assign reply_last = rx_valid_i && (reply_cnt_q == REPLY_CNT_W'(RESP_BYTES - 1));

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			IDLE:
				if (begin_i)
					state_d = WAIT_DATA;
			WAIT_DATA:
				if (data_ready)
					state_d = LOAD_WORD;
			LOAD_WORD:
				state_d = STORED;
			STORED:
				if (!want_at_i || knows_stored_i)
					state_d = data_complete ? byte_entry : WAIT_DATA;
			WAIT_LINK:
				if (bt_state_i)
					state_d = POP_BYTE;
			POP_BYTE:
				state_d = SEND_BYTE;
			SEND_BYTE:
				if (tx_done_i)
					state_d = NEXT_BYTE;
			NEXT_BYTE:
				if (!tx_empty_i)
					state_d = byte_entry;
				else
					state_d = want_at_i ? GET_REPLY : DONE;
			GET_REPLY:
				if (reply_last)
					state_d = WAIT_DEMAND;
			WAIT_DEMAND:
				if (access_rx_i)
					state_d = READ_WORD;
			READ_WORD:
				state_d = OFFER_WORD;
			OFFER_WORD:
				if (received_i)
					state_d = finished_rx_i ? DONE : WAIT_DEMAND;
			DONE:
				if (!begin_i)
					state_d = IDLE;
			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state_q <= IDLE;
			word_cnt_q <= '0;
			reply_cnt_q <= '0;
			pop_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			pop_q <= tx_pop_o;
			if (state_q == IDLE)
			begin
				word_cnt_q <= '0;
				reply_cnt_q <= '0;
			end
			else
			begin
				if (state_q == LOAD_WORD && !want_at_i)
					word_cnt_q <= word_cnt_q + 1'b1;
				if (state_q == GET_REPLY && rx_valid_i)
					reply_cnt_q <= reply_cnt_q + 1'b1;
			end
		end
	end

	assign tx_push_o = (state_q == LOAD_WORD);
	assign tx_pop_o = (state_q == POP_BYTE);
	// SEND_BYTE is only entered from POP_BYTE, so pop_q marks its first cycle
	assign tx_start_o = (state_q == SEND_BYTE) && pop_q;
	// The TX FIFO output register holds the popped byte until the next pop
	assign tx_byte_o = tx_rbyte_i;
	assign rx_pop_o = (state_q == READ_WORD);
	assign word_stored_o = (state_q == STORED);
	assign word_valid_o = (state_q == OFFER_WORD);
	assign done_o = (state_q == DONE);

endmodule

`default_nettype wire

// ==== src/bt_bridge_top.sv ====
/*
	Serial bridge to a Bluetooth radio module. want_at_i picks the word
	source: host words in command mode, sensor samples in sensor mode.
	Single clock domain; uart_rxd_i is synchronized inside the receiver.
*/

`timescale 1ns/1ps
`default_nettype none

module bt_bridge_top (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      bt_state_i,
	input  logic                      uart_rxd_i,
	input  logic [bt_pkg::WORD_W-1:0] host_word_i,
	input  logic [bt_pkg::WORD_W-1:0] sensor_word_i,
	input  logic                      begin_i,
	input  logic                      want_at_i,
	input  logic                      data_loaded_i,
	input  logic                      knows_stored_i,
	input  logic                      data_done_i,
	input  logic                      access_rx_i,
	input  logic                      received_i,
	input  logic                      finished_rx_i,
	output logic                      uart_txd_o,
	output logic [bt_pkg::WORD_W-1:0] rx_word_o,
	output logic                      word_stored_o,
	output logic                      word_valid_o,
	output logic                      done_o
);
	import bt_pkg::*;

	logic              tx_push;
	logic [WORD_W-1:0] tx_wdata;
	logic              tx_pop;
	logic [BYTE_W-1:0] tx_rbyte;
	logic              tx_empty;
	logic              tx_full;
	logic              tx_start;
	logic [BYTE_W-1:0] tx_byte;
	logic              tx_done;
	logic              rx_valid;
	logic [BYTE_W-1:0] rx_byte;
	logic              rx_pop;

	// Word source for the TX FIFO
	assign tx_wdata = want_at_i ? host_word_i : sensor_word_i;

	bt_link_ctrl i_ctrl (
		.clock          (clock),
		.reset          (reset),
		.begin_i        (begin_i),
		.want_at_i      (want_at_i),
		.data_loaded_i  (data_loaded_i),
		.knows_stored_i (knows_stored_i),
		.data_done_i    (data_done_i),
		.access_rx_i    (access_rx_i),
		.received_i     (received_i),
		.finished_rx_i  (finished_rx_i),
		.bt_state_i     (bt_state_i),
		.tx_empty_i     (tx_empty),
		.tx_rbyte_i     (tx_rbyte),
		.tx_done_i      (tx_done),
		.rx_valid_i     (rx_valid),
		.tx_push_o      (tx_push),
		.tx_pop_o       (tx_pop),
		.tx_start_o     (tx_start),
		.tx_byte_o      (tx_byte),
		.rx_pop_o       (rx_pop),
		.word_stored_o  (word_stored_o),
		.word_valid_o   (word_valid_o),
		.done_o         (done_o)
	);

	tx_fifo i_tx_fifo (
		.clock   (clock),
		.reset   (reset),
		.push_i  (tx_push),
		.wdata_i (tx_wdata),
		.pop_i   (tx_pop),
		.rbyte_o (tx_rbyte),
		.empty_o (tx_empty),
		.full_o  (tx_full)
	);

	uart_tx i_uart_tx (
		.clock   (clock),
		.reset   (reset),
		.start_i (tx_start),
		.byte_i  (tx_byte),
		.txd_o   (uart_txd_o),
		.done_o  (tx_done)
	);

	uart_rx i_uart_rx (
		.clock   (clock),
		.reset   (reset),
		.rxd_i   (uart_rxd_i),
		.byte_o  (rx_byte),
		.valid_o (rx_valid)
	);

	// Every received byte is stored, in and out of reply capture
	rx_fifo i_rx_fifo (
		.clock   (clock),
		.reset   (reset),
		.push_i  (rx_valid),
		.wbyte_i (rx_byte),
		.pop_i   (rx_pop),
		.rword_o (rx_word_o),
		.empty_o (),
		.full_o  ()
	);

endmodule

`default_nettype wire

// ==== testbench/bt_bridge_chk.sv ====
/*
	Concurrent checks on the bridge top level, bound into every instance.
	All checks are off while reset is high.
	fail_count holds the number of failed checks.
*/

`timescale 1ns/1ps
`default_nettype none

module bt_bridge_chk (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       tx_push_i,
	input  logic                       tx_full_i,
	input  logic                       tx_busy_i,
	input  logic                       tx_start_i,
	input  bt_pkg::link_state_e        state_i,
	input  logic                       uart_txd_i,
	input  logic                       word_valid_i,
	input  logic                       done_i
);
	import bt_pkg::*;

	int unsigned fail_count = 0;

	// A push into a full TX FIFO would lose a word
	a_push_not_full: assert property (@(posedge clock) disable iff (reset)
		tx_push_i |-> !tx_full_i)
	else
	begin
		$error("TX FIFO pushed while full");
		fail_count++;
	end

	a_valid_done_apart: assert property (@(posedge clock) disable iff (reset)
		!(word_valid_i && done_i))
	else
	begin
		$error("word_valid_o and done_o high together");
		fail_count++;
	end

	// Serial line idles high whenever no byte is being sent
	a_line_idle_high: assert property (@(posedge clock) disable iff (reset)
		(state_i != SEND_BYTE) |-> uart_txd_i)
	else
	begin
		$error("uart_txd_o low while the transmitter is idle");
		fail_count++;
	end

	// A start pulse must reach an idle transmitter
	a_start_in_send: assert property (@(posedge clock) disable iff (reset)
		tx_start_i |-> (state_i == SEND_BYTE) && !tx_busy_i)
	else
	begin
		$error("tx_start high outside SEND_BYTE or while the transmitter is busy");
		fail_count++;
	end

endmodule

bind bt_bridge_top bt_bridge_chk i_chk (
	.clock        (clock),
	.reset        (reset),
	.tx_push_i    (tx_push),
	.tx_full_i    (tx_full),
	.tx_busy_i    (i_uart_tx.busy_q),
	.tx_start_i   (tx_start),
	.state_i      (i_ctrl.state_q),
	.uart_txd_i   (uart_txd_o),
	.word_valid_i (word_valid_o),
	.done_i       (done_o)
);

`default_nettype wire

// ==== testbench/tb_bt_bridge.sv ====
/*
	Testbench for the Bluetooth bridge. Run from the project root so that
	testbench/bt_stim.txt is found. The stim file holds a fixed layout of
	words, see STIM_* below. Bytes on uart_txd_o are decoded at mid-bit.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_bt_bridge;
	import bt_pkg::*;

	localparam int HOST_WORDS = 3;
	localparam int REPLY_WORDS = RESP_BYTES / 2;
	// Layout of the stim file
	localparam int STIM_SENSOR_A = 0;
	localparam int STIM_HOST = STIM_SENSOR_A + SENSOR_WORDS;
	localparam int STIM_REPLY = STIM_HOST + HOST_WORDS;
	localparam int STIM_EXPECT = STIM_REPLY + RESP_BYTES;
	localparam int STIM_SENSOR_B = STIM_EXPECT + REPLY_WORDS;
	localparam int STIM_LEN = STIM_SENSOR_B + SENSOR_WORDS;
	// Two full sensor frames, one cut short by reset, host words and replies
	localparam int TOTAL_BYTES = 3 * 2 * SENSOR_WORDS + 2 * HOST_WORDS + RESP_BYTES;
	localparam int CYCLE_LIMIT = TOTAL_BYTES * 12 * CLKS_PER_BIT + 2000;

	logic              clock;
	logic              reset;
	logic              bt_state_i;
	logic              uart_rxd_i;
	logic [WORD_W-1:0] host_word_i;
	logic [WORD_W-1:0] sensor_word_i;
	logic              begin_i;
	logic              want_at_i;
	logic              data_loaded_i;
	logic              knows_stored_i;
	logic              data_done_i;
	logic              access_rx_i;
	logic              received_i;
	logic              finished_rx_i;
	wire               uart_txd_o;
	wire  [WORD_W-1:0] rx_word_o;
	wire               word_stored_o;
	wire               word_valid_o;
	wire               done_o;

	logic [WORD_W-1:0] stim_mem [STIM_LEN];
	int unsigned       cycle_count = 0;

	bt_bridge_top i_dut (
		.clock          (clock),
		.reset          (reset),
		.bt_state_i     (bt_state_i),
		.uart_rxd_i     (uart_rxd_i),
		.host_word_i    (host_word_i),
		.sensor_word_i  (sensor_word_i),
		.begin_i        (begin_i),
		.want_at_i      (want_at_i),
		.data_loaded_i  (data_loaded_i),
		.knows_stored_i (knows_stored_i),
		.data_done_i    (data_done_i),
		.access_rx_i    (access_rx_i),
		.received_i     (received_i),
		.finished_rx_i  (finished_rx_i),
		.uart_txd_o     (uart_txd_o),
		.rx_word_o      (rx_word_o),
		.word_stored_o  (word_stored_o),
		.word_valid_o   (word_valid_o),
		.done_o         (done_o)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#10 clock = ~clock;
	end

	task automatic stop_failed();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
			stop_failed();
		end
	endtask

	// Watchdog and checker monitor
	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			stop_failed();
		end
		else if (i_dut.i_chk.fail_count != 0)
		begin
			$display("An assertion in the bound checker failed");
			stop_failed();
		end
	end

	// Decodes one 8N1 frame from uart_txd_o
	task automatic receive_byte(output logic [BYTE_W-1:0] value);
		int i;
		do
			@(negedge clock);
		while (uart_txd_o === 1'b1);
		repeat (CLKS_PER_BIT / 2) @(negedge clock);
		check_value("uart_txd_o start bit", uart_txd_o, 0);
		for (i = 0; i < BYTE_W; i++)
		begin
			repeat (CLKS_PER_BIT) @(negedge clock);
			value[i] = uart_txd_o;
		end
		repeat (CLKS_PER_BIT) @(negedge clock);
		check_value("uart_txd_o stop bit", uart_txd_o, 1);
	endtask

	// Drives one 8N1 frame into uart_rxd_i, LSB first
	task automatic send_byte(input logic [BYTE_W-1:0] value);
		int i;
		uart_rxd_i = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge clock);
		for (i = 0; i < BYTE_W; i++)
		begin
			uart_rxd_i = value[i];
			repeat (CLKS_PER_BIT) @(negedge clock);
		end
		uart_rxd_i = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge clock);
	endtask

	// Each word goes out high byte first
	task automatic expect_frame_bytes(input int base, input int words);
		logic [BYTE_W-1:0] got;
		int w;
		for (w = 0; w < words; w++)
		begin
			receive_byte(got);
			check_value("uart_txd_o high byte", got, stim_mem[base + w][WORD_W-1:BYTE_W]);
			receive_byte(got);
			check_value("uart_txd_o low byte", got, stim_mem[base + w][BYTE_W-1:0]);
		end
	endtask

	task automatic load_sensor_frame(input int base);
		int w;
		sensor_word_i = stim_mem[base];
		begin_i = 1'b1;
		for (w = 0; w < SENSOR_WORDS; w++)
		begin
			do
				@(negedge clock);
			while (!word_stored_o);
			// STORED marks the push, so the next sample can be shown
			if (w + 1 < SENSOR_WORDS)
				sensor_word_i = stim_mem[base + w + 1];
		end
	endtask

	task automatic end_session();
		@(negedge clock);
		check_value("done_o", done_o, 1);
		begin_i = 1'b0;
		@(negedge clock);
		check_value("done_o", done_o, 0);
	endtask

	task automatic sensor_session(input int base);
		int delay;
		want_at_i = 1'b0;
		bt_state_i = 1'b0;
		load_sensor_frame(base);
		// No start bit may appear without a link
		delay = 8 + $urandom % 32;
		repeat (delay)
		begin
			@(negedge clock);
			check_value("uart_txd_o", uart_txd_o, 1);
		end
		bt_state_i = 1'b1;
		expect_frame_bytes(base, SENSOR_WORDS);
		do
			@(negedge clock);
		while (!done_o);
		bt_state_i = 1'b0;
		end_session();
	endtask

	task automatic command_session();
		int w;
		int b;
		int delay;
		want_at_i = 1'b1;
		bt_state_i = 1'b0;
		begin_i = 1'b1;
		for (w = 0; w < HOST_WORDS; w++)
		begin
			host_word_i = stim_mem[STIM_HOST + w];
			data_done_i = (w == HOST_WORDS - 1);
			data_loaded_i = 1'b1;
			do
				@(negedge clock);
			while (!word_stored_o);
			data_loaded_i = 1'b0;
			delay = $urandom % 16;
			repeat (delay)
			begin
				@(negedge clock);
				check_value("word_stored_o", word_stored_o, 1);
			end
			knows_stored_i = 1'b1;
			@(negedge clock);
			knows_stored_i = 1'b0;
			data_done_i = 1'b0;
			check_value("word_stored_o", word_stored_o, 0);
		end
		expect_frame_bytes(STIM_HOST, HOST_WORDS);

		// Reply from the radio
		delay = 4 + $urandom % 16;
		repeat (delay) @(negedge clock);
		for (b = 0; b < RESP_BYTES; b++)
			send_byte(stim_mem[STIM_REPLY + b][BYTE_W-1:0]);

		for (w = 0; w < REPLY_WORDS; w++)
		begin
			access_rx_i = 1'b1;
			do
				@(negedge clock);
			while (!word_valid_o);
			access_rx_i = 1'b0;
			check_value("rx_word_o", rx_word_o, stim_mem[STIM_EXPECT + w]);
			delay = $urandom % 16;
			repeat (delay)
			begin
				@(negedge clock);
				check_value("word_valid_o", word_valid_o, 1);
				check_value("rx_word_o", rx_word_o, stim_mem[STIM_EXPECT + w]);
			end
			received_i = 1'b1;
			finished_rx_i = (w == REPLY_WORDS - 1);
			@(negedge clock);
			received_i = 1'b0;
			finished_rx_i = 1'b0;
			check_value("word_valid_o", word_valid_o, 0);
		end
		check_value("done_o", done_o, 1);
		end_session();
	endtask

	task automatic reset_mid_send();
		want_at_i = 1'b0;
		bt_state_i = 1'b1;
		load_sensor_frame(STIM_SENSOR_B);
		do
			@(negedge clock);
		while (uart_txd_o);
		repeat (3 * CLKS_PER_BIT) @(negedge clock);
		reset = 1'b1;
		begin_i = 1'b0;
		bt_state_i = 1'b0;
		@(negedge clock);
		check_value("uart_txd_o", uart_txd_o, 1);
		check_value("word_stored_o", word_stored_o, 0);
		check_value("word_valid_o", word_valid_o, 0);
		check_value("done_o", done_o, 0);
		repeat (4) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		sensor_session(STIM_SENSOR_B);
	endtask

	initial
	begin
		void'($urandom(70));
		reset = 1'b1;
		bt_state_i = 1'b0;
		uart_rxd_i = 1'b1;
		host_word_i = '0;
		sensor_word_i = '0;
		begin_i = 1'b0;
		want_at_i = 1'b0;
		data_loaded_i = 1'b0;
		knows_stored_i = 1'b0;
		data_done_i = 1'b0;
		access_rx_i = 1'b0;
		received_i = 1'b0;
		finished_rx_i = 1'b0;
		$readmemh("testbench/bt_stim.txt", stim_mem);
		if ($isunknown(stim_mem[STIM_LEN - 1]))
		begin
			$display("Stimulus file testbench/bt_stim.txt is missing or too short");
			stop_failed();
		end

		repeat (5) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		sensor_session(STIM_SENSOR_A);
		command_session();
		reset_mid_send();

		repeat (4) @(negedge clock);
		if (i_dut.i_chk.fail_count == 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
		begin
			$display("An assertion in the bound checker failed");
			stop_failed();
		end
	end

endmodule

`default_nettype wire

// ==== testbench/bt_stim.txt ====
// One 16-bit hex value per line: sensor frame A, host words, reply bytes,
// expected reply words, sensor frame B
// Sensor frame A
1234
abcd
00ff
8001
// Host words
4154
2b56
0d0a
// Reply bytes, in arrival order
004f
004b
000d
000a
// Expected reply words, first byte high
4f4b
0d0a
// Sensor frame B, first cut by reset, then sent again
5a5a
c3e1
7f80
0102

// ==== tb.f ====
common/bt_pkg.sv
src/tx_fifo.sv
src/rx_fifo.sv
uart/uart_tx.sv
uart/uart_rx.sv
src/bt_link_ctrl.sv
src/bt_bridge_top.sv
testbench/bt_bridge_chk.sv
testbench/tb_bt_bridge.sv

// ==== Bender.yml ====
package:
  name: bt_bridge

sources:
  - common/bt_pkg.sv
  - src/tx_fifo.sv
  - src/rx_fifo.sv
  - uart/uart_tx.sv
  - uart/uart_rx.sv
  - src/bt_link_ctrl.sv
  - src/bt_bridge_top.sv
  - target: test
    files:
      - testbench/bt_bridge_chk.sv
      - testbench/tb_bt_bridge.sv
